// File: vlog.f
isaPkg.sv
pipePkg.sv
fetchUnit.sv
regFile.sv
decodeStage.sv
executeStage.sv
cpuCore.sv
memModels.sv
cpuTb.sv

// File: Makefile
SOURCES = isaPkg.sv pipePkg.sv fetchUnit.sv regFile.sv decodeStage.sv \
          executeStage.sv cpuCore.sv memModels.sv cpuTb.sv

.PHONY: all run check clean

all: check

obj_dir/VcpuTb: vlog.f $(SOURCES)
	verilator --binary --timing --assert -j 0 --top-module cpuTb -f vlog.f

run: obj_dir/VcpuTb
	./obj_dir/VcpuTb > sim.log 2>&1; status=$$?; cat sim.log; exit $$status

check: run
	@if grep -q "Test failed" sim.log; then \
		echo "Failure reported in sim.log"; \
		exit 1; \
	fi
	@echo "No failure reported in sim.log"

clean:
	rm -rf obj_dir sim.log

// File: cpuTb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTb import isaPkg::*; ();

    localparam word_t resetPc      = 32'hbfc0_0000;
    localparam int    eventTimeout = 100;
    localparam int    quietCycles  = 40;

    logic       clk;
    logic       reset;
    word_t      instAddr;
    logic       instReadEn;
    word_t      instRdata;
    logic       instValid;
    word_t      dataAddr;
    word_t      dataWdata;
    logic       dataRead;
    logic       dataWrite;
    word_t      dataRdata;
    logic       dataValid;
    word_t      debugWbPc;
    logic [3:0] debugWbRfWen;
    regAddr_t   debugWbRfWnum;
    word_t      debugWbRfWdata;

    int       errorCount;
    int       checkCount;
    string    currentTest;
    word_t    prog [$];
    word_t    expPc [$];
    regAddr_t expNum [$];
    word_t    expData [$];
    word_t    modelRegs [32];
    word_t    modelMem [word_t];

    always #2 clk = ~clk;

    cpuCore #(
        .resetPc(resetPc)
    ) DUT (
        .clk(clk),
        .reset(reset),
        .instAddr(instAddr),
        .instReadEn(instReadEn),
        .instRdata(instRdata),
        .instValid(instValid),
        .dataAddr(dataAddr),
        .dataWdata(dataWdata),
        .dataRead(dataRead),
        .dataWrite(dataWrite),
        .dataRdata(dataRdata),
        .dataValid(dataValid),
        .debugWbPc(debugWbPc),
        .debugWbRfWen(debugWbRfWen),
        .debugWbRfWnum(debugWbRfWnum),
        .debugWbRfWdata(debugWbRfWdata)
    );

    instRom #(
        .baseAddr(resetPc)
    ) rom (
        .clk(clk),
        .reset(reset),
        .instAddr(instAddr),
        .instReadEn(instReadEn),
        .instRdata(instRdata),
        .instValid(instValid)
    );

    dataRam ram (
        .clk(clk),
        .reset(reset),
        .dataAddr(dataAddr),
        .dataRead(dataRead),
        .dataWrite(dataWrite),
        .dataWdata(dataWdata),
        .dataRdata(dataRdata),
        .dataValid(dataValid)
    );

    function automatic word_t rType(funct_t fn, regAddr_t rd, regAddr_t rs, regAddr_t rt);
        return {opSpecial, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t iType(opcode_t op, regAddr_t rt, regAddr_t rs, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Runs the program in order and lists the expected writebacks
    function automatic void predict();
        word_t    inst;
        word_t    a;
        word_t    b;
        word_t    sImm;
        word_t    zImm;
        word_t    result;
        regAddr_t dest;

        expPc.delete();
        expNum.delete();
        expData.delete();
        modelMem.delete();
        foreach (modelRegs[r]) begin
            modelRegs[r] = '0;
        end
        foreach (prog[i]) begin
            inst   = prog[i];
            a      = modelRegs[inst[25:21]];
            b      = modelRegs[inst[20:16]];
            sImm   = {{16{inst[15]}}, inst[15:0]};
            zImm   = {16'h0, inst[15:0]};
            dest   = '0;
            result = '0;
            case (opcode_t'(inst[31:26]))
                opSpecial: begin
                    dest = inst[15:11];
                    case (funct_t'(inst[5:0]))
                        fnAddu:  result = a + b;
                        fnSubu:  result = a - b;
                        fnAnd:   result = a & b;
                        fnOr:    result = a | b;
                        fnXor:   result = a ^ b;
                        fnSlt:   result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: dest = '0;
                    endcase
                end
                opAddiu: begin
                    dest   = inst[20:16];
                    result = a + sImm;
                end
                opAndi: begin
                    dest   = inst[20:16];
                    result = a & zImm;
                end
                opOri: begin
                    dest   = inst[20:16];
                    result = a | zImm;
                end
                opLui: begin
                    dest   = inst[20:16];
                    result = {inst[15:0], 16'h0};
                end
                opLw: begin
                    dest   = inst[20:16];
                    result = modelMem[a + sImm];
                end
                opSw: modelMem[a + sImm] = b;
                default: ;
            endcase
            if (dest != '0) begin
                modelRegs[dest] = result;
                expPc.push_back(resetPc + word_t'(4 * i));
                expNum.push_back(dest);
                expData.push_back(result);
            end
        end
    endfunction

    task automatic checkValue(input string name, input word_t expected, input word_t actual);
        checkCount++;
        assert (actual === expected) else begin
            errorCount++;
            $display("Error: %s expected %h, got %h (%s)", name, expected, actual, currentTest);
        end
    endtask

    // Sampled on the rising edge before the core updates
    task automatic waitWriteback(output bit seen, output word_t pc, output regAddr_t num,
                                 output word_t data, output logic [3:0] wen);
        int cycles;

        seen = 1'b0;
        for (cycles = 0; cycles < eventTimeout && !seen; cycles++) begin
            @(posedge clk);
            if (debugWbRfWen != 4'h0) begin
                seen = 1'b1;
                pc   = debugWbPc;
                num  = debugWbRfWnum;
                data = debugWbRfWdata;
                wen  = debugWbRfWen;
            end
        end
    endtask

    task automatic runProgram();
        bit         seen;
        word_t      gotPc;
        regAddr_t   gotNum;
        word_t      gotData;
        logic [3:0] gotWen;
        int         k;

        @(negedge clk);
        reset = 1'b1;
        for (k = 0; k < 256; k++) begin
            rom.mem[k] = (k < prog.size()) ? prog[k] : '0;
        end
        predict();
        repeat (10) @(negedge clk);
        reset = 1'b0;
        foreach (expPc[n]) begin
            waitWriteback(seen, gotPc, gotNum, gotData, gotWen);
            if (!seen) begin
                errorCount++;
                $display("%s: no writeback %0d of %0d within %0d cycles",
                         currentTest, n + 1, expPc.size(), eventTimeout);
                return;
            end
            checkValue("debugWbPc", expPc[n], gotPc);
            checkValue("debugWbRfWnum", word_t'(expNum[n]), word_t'(gotNum));
            checkValue("debugWbRfWdata", expData[n], gotData);
            checkValue("debugWbRfWen", 32'hf, word_t'(gotWen));
        end
        // Trailing instructions must retire silently
        for (k = 0; k < quietCycles; k++) begin
            @(posedge clk);
            checkCount++;
            assert (debugWbRfWen == 4'h0) else begin
                errorCount++;
                $display("%s: unexpected writeback to register %0d from pc %h",
                         currentTest, debugWbRfWnum, debugWbPc);
            end
        end
    endtask

    task automatic independentOps();
        currentTest = "independent ops";
        prog.delete();
        prog.push_back(iType(opOri, 5'd1, 5'd0, 16'h1234));
        prog.push_back(iType(opOri, 5'd2, 5'd0, 16'h0f0f));
        prog.push_back(iType(opOri, 5'd3, 5'd0, 16'h8421));
        prog.push_back(rType(fnAddu, 5'd4, 5'd1, 5'd2));
        prog.push_back(rType(fnSubu, 5'd5, 5'd2, 5'd1));
        prog.push_back(rType(fnAnd, 5'd6, 5'd1, 5'd3));
        prog.push_back(rType(fnOr, 5'd7, 5'd2, 5'd3));
        prog.push_back(rType(fnXor, 5'd8, 5'd1, 5'd3));
        prog.push_back(rType(fnSlt, 5'd9, 5'd1, 5'd2));
        runProgram();
    endtask

    task automatic forwardingChain();
        currentTest = "forwarding chain";
        prog.delete();
        prog.push_back(iType(opOri, 5'd1, 5'd0, 16'h0005));
        prog.push_back(rType(fnAddu, 5'd2, 5'd1, 5'd1));
        prog.push_back(rType(fnAddu, 5'd3, 5'd2, 5'd1));
        prog.push_back(rType(fnSubu, 5'd4, 5'd1, 5'd3));
        prog.push_back(rType(fnXor, 5'd5, 5'd4, 5'd3));
        prog.push_back(rType(fnOr, 5'd6, 5'd5, 5'd2));
        prog.push_back(rType(fnSlt, 5'd7, 5'd4, 5'd6));
        prog.push_back(rType(fnAnd, 5'd8, 5'd7, 5'd6));
        runProgram();
    endtask

    task automatic immediateExtension();
        currentTest = "immediate extension";
        prog.delete();
        prog.push_back(iType(opAddiu, 5'd1, 5'd0, 16'hfffc));
        prog.push_back(iType(opAddiu, 5'd2, 5'd1, 16'h8000));
        prog.push_back(iType(opAndi, 5'd3, 5'd1, 16'h8ff0));
        prog.push_back(iType(opOri, 5'd4, 5'd0, 16'h9abc));
        prog.push_back(iType(opLui, 5'd5, 5'd0, 16'h8765));
        prog.push_back(iType(opOri, 5'd6, 5'd5, 16'hf00f));
        prog.push_back(rType(fnSlt, 5'd7, 5'd1, 5'd0));
        prog.push_back(rType(fnSlt, 5'd8, 5'd0, 5'd1));
        prog.push_back(rType(fnSlt, 5'd9, 5'd5, 5'd4));
        runProgram();
    endtask

    task automatic storeThenLoad();
        currentTest = "store then load";
        prog.delete();
        prog.push_back(iType(opOri, 5'd1, 5'd0, 16'h0040));
        prog.push_back(iType(opLui, 5'd2, 5'd0, 16'hcafe));
        prog.push_back(iType(opOri, 5'd2, 5'd2, 16'hf00d));
        prog.push_back(iType(opSw, 5'd2, 5'd1, 16'h0004));
        prog.push_back(iType(opLw, 5'd3, 5'd1, 16'h0004));
        prog.push_back(iType(opAddiu, 5'd4, 5'd0, 16'h1357));
        prog.push_back(iType(opSw, 5'd4, 5'd1, 16'hfffc));
        prog.push_back(iType(opLw, 5'd5, 5'd1, 16'hfffc));
        runProgram();
    endtask

    task automatic loadUse();
        currentTest = "load use";
        prog.delete();
        prog.push_back(iType(opOri, 5'd1, 5'd0, 16'h0020));
        prog.push_back(iType(opOri, 5'd2, 5'd0, 16'h1111));
        prog.push_back(iType(opLui, 5'd3, 5'd0, 16'h2222));
        prog.push_back(iType(opSw, 5'd2, 5'd1, 16'h0000));
        prog.push_back(iType(opSw, 5'd3, 5'd1, 16'h0008));
        prog.push_back(iType(opLw, 5'd4, 5'd1, 16'h0000));
        prog.push_back(rType(fnAddu, 5'd5, 5'd4, 5'd2));
        prog.push_back(iType(opLw, 5'd6, 5'd1, 16'h0008));
        prog.push_back(rType(fnAddu, 5'd7, 5'd1, 5'd6));
        prog.push_back(iType(opLw, 5'd8, 5'd1, 16'h0000));
        prog.push_back(rType(fnAddu, 5'd9, 5'd2, 5'd8));
        runProgram();
    endtask

    task automatic registerZero();
        currentTest = "register zero";
        prog.delete();
        prog.push_back(iType(opOri, 5'd1, 5'd0, 16'h0077));
        prog.push_back(iType(opAddiu, 5'd0, 5'd1, 16'h0005));
        prog.push_back(iType(opOri, 5'd0, 5'd1, 16'hffff));
        prog.push_back(rType(fnAddu, 5'd0, 5'd1, 5'd1));
        prog.push_back(rType(fnAddu, 5'd2, 5'd0, 5'd0));
        prog.push_back(rType(fnOr, 5'd3, 5'd0, 5'd1));
        prog.push_back(iType(opAddiu, 5'd4, 5'd0, 16'h0001));
        prog.push_back(rType(fnAddu, 5'd0, 5'd4, 5'd4));
        runProgram();
    endtask

    initial begin
        void'($urandom(32'hfc50_dce0));
        clk        = 1'b0;
        reset      = 1'b1;
        errorCount = 0;
        checkCount = 0;
        independentOps();
        forwardingChain();
        immediateExtension();
        storeThenLoad();
        loadUse();
        registerZero();
        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: memModels.sv
`timescale 1ns/1ps
`default_nettype none

module instRom import isaPkg::*; #(
    parameter word_t baseAddr = 32'hbfc0_0000
) (
    input  wire        clk,
    input  wire        reset,
    input  wire word_t instAddr,
    input  wire        instReadEn,
    output word_t      instRdata,
    output logic       instValid
);

    word_t mem [0:255];
    logic  pending;
    int    delay;
    word_t offset;

    initial begin
        instRdata = '0;
        instValid = 1'b0;
        pending   = 1'b0;
        delay     = 0;
    end

    // Answers change on the falling edge only
    always @(negedge clk) begin
        offset = (instAddr - baseAddr) >> 2;
        if (reset || instValid) begin
            instValid = 1'b0;
            pending   = 1'b0;
        end else if (instReadEn) begin
            if (!pending) begin
                pending = 1'b1;
                delay   = $urandom_range(3, 0);
            end
            if (delay == 0) begin
                instValid = 1'b1;
                // Past the loaded image reads as a no-op
                instRdata = (offset < 256) ? mem[offset[7:0]] : '0;
            end else begin
                delay--;
            end
        end
    end

endmodule

module dataRam import isaPkg::*; (
    input  wire        clk,
    input  wire        reset,
    input  wire word_t dataAddr,
    input  wire        dataRead,
    input  wire        dataWrite,
    input  wire word_t dataWdata,
    output word_t      dataRdata,
    output logic       dataValid
);

    word_t mem [0:63];
    logic  pending;
    int    delay;

    initial begin
        dataRdata = '0;
        dataValid = 1'b0;
        pending   = 1'b0;
        delay     = 0;
    end

    always @(negedge clk) begin
        if (reset) begin
            dataValid = 1'b0;
            pending   = 1'b0;
            // Background pattern from the full byte address
            for (int i = 0; i < 64; i++) begin
                mem[i] = 32'hdead_0000 ^ ~(word_t'(i) << 2);
            end
        end else if (dataValid) begin
            dataValid = 1'b0;
            pending   = 1'b0;
        end else if (dataRead || dataWrite) begin
            if (!pending) begin
                pending = 1'b1;
                delay   = $urandom_range(4, 1);
            end
            if (delay == 0) begin
                dataValid = 1'b1;
                if (dataWrite) begin
                    mem[dataAddr[7:2]] = dataWdata;
                end else begin
                    dataRdata = mem[dataAddr[7:2]];
                end
            end else begin
                delay--;
            end
        end
    end

endmodule

`default_nettype wire

// File: cpuCore.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCore import isaPkg::*, pipePkg::*; #(
    parameter word_t resetPc = 32'hbfc0_0000
) (
    input  wire        clk,
    input  wire        reset,
    output word_t      instAddr,
    output logic       instReadEn,
    input  wire word_t instRdata,
    input  wire        instValid,
    output word_t      dataAddr,
    output word_t      dataWdata,
    output logic       dataRead,
    output logic       dataWrite,
    input  wire word_t dataRdata,
    input  wire        dataValid,
    output word_t      debugWbPc,
    output logic [3:0] debugWbRfWen,
    output regAddr_t   debugWbRfWnum,
    output word_t      debugWbRfWdata
);

    logic     fetchValid;
    word_t    fetchInst;
    word_t    fetchPc;
    logic     decodeStall;
    regAddr_t readAddr1;
    regAddr_t readAddr2;
    word_t    readData1;
    word_t    readData2;
    logic     fwdValid;
    regAddr_t fwdDest;
    word_t    fwdValue;
    logic     exBusy;
    logic     exLoadValid;
    regAddr_t exLoadDest;
    logic     issueValid;
    word_t    issuePc;
    regAddr_t issueDest;
    word_t    issueResult;
    word_t    issueStoreData;
    memOp_t   issueMemOp;
    wbSrc_t   issueWbSrc;
    regAddr_t wbAddr;
    word_t    wbData;

    fetchUnit #(
        .resetPc(resetPc)
    ) fetch (
        .clk(clk),
        .reset(reset),
        .instAddr(instAddr),
        .instReadEn(instReadEn),
        .instRdata(instRdata),
        .instValid(instValid),
        .decodeStall(decodeStall),
        .fetchValid(fetchValid),
        .fetchInst(fetchInst),
        .fetchPc(fetchPc)
    );

    decodeStage decode (
        .clk(clk),
        .reset(reset),
        .fetchValid(fetchValid),
        .fetchInst(fetchInst),
        .fetchPc(fetchPc),
        .decodeStall(decodeStall),
        .readAddr1(readAddr1),
        .readAddr2(readAddr2),
        .readData1(readData1),
        .readData2(readData2),
        .fwdValid(fwdValid),
        .fwdDest(fwdDest),
        .fwdValue(fwdValue),
        .exBusy(exBusy),
        .exLoadValid(exLoadValid),
        .exLoadDest(exLoadDest),
        .issueValid(issueValid),
        .issuePc(issuePc),
        .issueDest(issueDest),
        .issueResult(issueResult),
        .issueStoreData(issueStoreData),
        .issueMemOp(issueMemOp),
        .issueWbSrc(issueWbSrc)
    );

    regFile regs (
        .clk(clk),
        .reset(reset),
        .readAddr1(readAddr1),
        .readAddr2(readAddr2),
        .readData1(readData1),
        .readData2(readData2),
        .wbAddr(wbAddr),
        .wbData(wbData)
    );

    executeStage execute (
        .clk(clk),
        .reset(reset),
        .issueValid(issueValid),
        .issuePc(issuePc),
        .issueDest(issueDest),
        .issueResult(issueResult),
        .issueStoreData(issueStoreData),
        .issueMemOp(issueMemOp),
        .issueWbSrc(issueWbSrc),
        .exBusy(exBusy),
        .exLoadValid(exLoadValid),
        .exLoadDest(exLoadDest),
        .fwdValid(fwdValid),
        .fwdDest(fwdDest),
        .fwdValue(fwdValue),
        .dataAddr(dataAddr),
        .dataRead(dataRead),
        .dataWrite(dataWrite),
        .dataWdata(dataWdata),
        .dataRdata(dataRdata),
        .dataValid(dataValid),
        .wbAddr(wbAddr),
        .wbData(wbData),
        .debugWbPc(debugWbPc),
        .debugWbRfWen(debugWbRfWen),
        .debugWbRfWnum(debugWbRfWnum),
        .debugWbRfWdata(debugWbRfWdata)
    );

endmodule

`default_nettype wire

// File: executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage import isaPkg::*, pipePkg::*; (
    input  wire           clk,
    input  wire           reset,
    input  wire           issueValid,
    input  wire word_t    issuePc,
    input  wire regAddr_t issueDest,
    input  wire word_t    issueResult,
    input  wire word_t    issueStoreData,
    input  wire memOp_t   issueMemOp,
    input  wire wbSrc_t   issueWbSrc,
    output logic          exBusy,
    output logic          exLoadValid,
    output regAddr_t      exLoadDest,
    output logic          fwdValid,
    output regAddr_t      fwdDest,
    output word_t         fwdValue,
    output word_t         dataAddr,
    output logic          dataRead,
    output logic          dataWrite,
    output word_t         dataWdata,
    input  wire word_t    dataRdata,
    input  wire           dataValid,
    output regAddr_t      wbAddr,
    output word_t         wbData,
    output word_t         debugWbPc,
    output logic [3:0]    debugWbRfWen,
    output regAddr_t      debugWbRfWnum,
    output word_t         debugWbRfWdata
);

    logic     exValid;
    word_t    exPc;
    regAddr_t exDest;
    word_t    exResult;
    word_t    exStoreData;
    memOp_t   exMemOp;
    wbSrc_t   exWbSrc;
    logic     memActive;
    logic     wbEn;

    // Instruction stays put while the data access is outstanding
    always_ff @(posedge clk) begin
        if (reset) begin
            exValid <= 1'b0;
        end else if (!exBusy) begin
            exValid <= issueValid;
        end
    end

    always_ff @(posedge clk) begin
        if (issueValid) begin
            exPc        <= issuePc;
            exDest      <= issueDest;
            exResult    <= issueResult;
            exStoreData <= issueStoreData;
            exMemOp     <= issueMemOp;
            exWbSrc     <= issueWbSrc;
        end
    end

    assign memActive   = exValid && exMemOp != memNone;
    assign exBusy      = memActive && !dataValid;
    assign exLoadValid = exBusy && exMemOp == memLoad;
    assign exLoadDest  = exDest;

    assign dataRead  = exValid && exMemOp == memLoad;
    assign dataWrite = exValid && exMemOp == memStore;
    assign dataAddr  = exResult;
    assign dataWdata = exStoreData;

    assign fwdValid = exValid && exWbSrc == wbAlu;
    assign fwdDest  = exDest;
    assign fwdValue = exResult;

    // Loads write back in the cycle the data arrives
    assign wbEn   = exValid && (exWbSrc == wbAlu || (exWbSrc == wbMem && dataValid));
    assign wbAddr = wbEn ? exDest : '0;
    assign wbData = (exWbSrc == wbMem) ? dataRdata : exResult;

    assign debugWbPc      = exPc;
    assign debugWbRfWen   = (wbAddr != '0) ? 4'hf : 4'h0;
    assign debugWbRfWnum  = wbAddr;
    assign debugWbRfWdata = wbData;

endmodule

`default_nettype wire

// File: decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage import isaPkg::*, pipePkg::*; (
    input  wire           clk,
    input  wire           reset,
    input  wire           fetchValid,
    input  wire word_t    fetchInst,
    input  wire word_t    fetchPc,
    output logic          decodeStall,
    output regAddr_t      readAddr1,
    output regAddr_t      readAddr2,
    input  wire word_t    readData1,
    input  wire word_t    readData2,
    input  wire           fwdValid,
    input  wire regAddr_t fwdDest,
    input  wire word_t    fwdValue,
    input  wire           exBusy,
    input  wire           exLoadValid,
    input  wire regAddr_t exLoadDest,
    output logic          issueValid,
    output word_t         issuePc,
    output regAddr_t      issueDest,
    output word_t         issueResult,
    output word_t         issueStoreData,
    output memOp_t        issueMemOp,
    output wbSrc_t        issueWbSrc
);

    logic     holdValid;
    word_t    holdInst;
    word_t    holdPc;
    opcode_t  opcode;
    funct_t   funct;
    regAddr_t rs;
    regAddr_t rt;
    regAddr_t rd;
    logic     readsRs;
    logic     readsRt;
    logic     useImm;
    logic     signExt;
    aluOp_t   aluOp;
    word_t    imm;
    word_t    opA;
    word_t    rtValue;
    word_t    opB;
    word_t    aluOut;
    logic     loadHazard;

    // ALU result sitting in execute overrides the register file
    function automatic word_t pickOperand(regAddr_t src, word_t rfValue);
        if (fwdValid && src != '0 && fwdDest == src) begin
            return fwdValue;
        end
        return rfValue;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            holdValid <= 1'b0;
        end else if (fetchValid) begin
            holdValid <= 1'b1;
        end else if (issueValid) begin
            holdValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fetchValid) begin
            holdInst <= fetchInst;
            holdPc   <= fetchPc;
        end
    end

    assign opcode    = opcode_t'(holdInst[31:26]);
    assign funct     = funct_t'(holdInst[5:0]);
    assign rs        = holdInst[25:21];
    assign rt        = holdInst[20:16];
    assign rd        = holdInst[15:11];
    assign readAddr1 = rs;
    assign readAddr2 = rt;

    always_comb begin
        aluOp      = aluAdd;
        issueMemOp = memNone;
        issueWbSrc = wbNone;
        issueDest  = '0;
        readsRs    = 1'b0;
        readsRt    = 1'b0;
        useImm     = 1'b1;
        signExt    = 1'b1;
        case (opcode)
            opSpecial: begin
                readsRs    = 1'b1;
                readsRt    = 1'b1;
                useImm     = 1'b0;
                issueDest  = rd;
                issueWbSrc = wbAlu;
                case (funct)
                    fnAddu:  aluOp = aluAdd;
                    fnSubu:  aluOp = aluSub;
                    fnAnd:   aluOp = aluAnd;
                    fnOr:    aluOp = aluOr;
                    fnXor:   aluOp = aluXor;
                    fnSlt:   aluOp = aluSlt;
                    default: begin
                        issueDest  = '0;
                        issueWbSrc = wbNone;
                    end
                endcase
            end
            opAddiu: begin
                readsRs    = 1'b1;
                issueDest  = rt;
                issueWbSrc = wbAlu;
            end
            opAndi, opOri: begin
                aluOp      = (opcode == opAndi) ? aluAnd : aluOr;
                signExt    = 1'b0;
                readsRs    = 1'b1;
                issueDest  = rt;
                issueWbSrc = wbAlu;
            end
            opLui: begin
                aluOp      = aluLui;
                signExt    = 1'b0;
                issueDest  = rt;
                issueWbSrc = wbAlu;
            end
            opLw: begin
                readsRs    = 1'b1;
                issueDest  = rt;
                issueMemOp = memLoad;
                issueWbSrc = wbMem;
            end
            opSw: begin
                readsRs    = 1'b1;
                readsRt    = 1'b1;
                issueMemOp = memStore;
            end
            // Anything else passes through as a no-op
            default: ;
        endcase
    end

    assign imm     = signExt ? {{16{holdInst[15]}}, holdInst[15:0]} : {16'h0, holdInst[15:0]};
    assign opB     = useImm ? imm : rtValue;

    always_comb begin
        opA     = pickOperand(rs, readData1);
        rtValue = pickOperand(rt, readData2);
    end

    always_comb begin
        case (aluOp)
            aluSub:  aluOut = opA - opB;
            aluAnd:  aluOut = opA & opB;
            aluOr:   aluOut = opA | opB;
            aluXor:  aluOut = opA ^ opB;
            aluSlt:  aluOut = {31'b0, $signed(opA) < $signed(opB)};
            aluLui:  aluOut = {opB[15:0], 16'h0};
            default: aluOut = opA + opB;
        endcase
    end

    // Loaded value not back yet
    assign loadHazard = exLoadValid && exLoadDest != '0 &&
                        ((readsRs && exLoadDest == rs) || (readsRt && exLoadDest == rt));

    assign decodeStall    = holdValid && (exBusy || loadHazard);
    assign issueValid     = holdValid && !decodeStall;
    assign issuePc        = holdPc;
    assign issueResult    = aluOut;
    assign issueStoreData = rtValue;

endmodule

`default_nettype wire

// File: regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile import isaPkg::*; (
    input  wire           clk,
    input  wire           reset,
    input  wire regAddr_t readAddr1,
    input  wire regAddr_t readAddr2,
    output word_t         readData1,
    output word_t         readData2,
    input  wire regAddr_t wbAddr,
    input  wire word_t    wbData
);

    word_t regs [1:31];

    // Same-cycle write is visible on the read port
    function automatic word_t readPort(regAddr_t addr);
        if (addr == '0) begin
            return '0;
        end else if (addr == wbAddr) begin
            return wbData;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wbAddr != '0) begin
            regs[wbAddr] <= wbData;
        end
    end

    always_comb begin
        readData1 = readPort(readAddr1);
        readData2 = readPort(readAddr2);
    end

endmodule

`default_nettype wire

// File: fetchUnit.sv
`timescale 1ns/1ps
`default_nettype none

module fetchUnit import isaPkg::*; #(
    parameter word_t resetPc = 32'hbfc0_0000
) (
    input  wire        clk,
    input  wire        reset,
    output word_t      instAddr,
    output logic       instReadEn,
    input  wire word_t instRdata,
    input  wire        instValid,
    input  wire        decodeStall,
    output logic       fetchValid,
    output word_t      fetchInst,
    output word_t      fetchPc
);

    word_t pc;
    logic  reqActive;
    logic  bufValid;

    assign instAddr   = pc;
    assign instReadEn = reqActive;

    // Returned word waits here until decode takes it
    assign fetchValid = bufValid && !decodeStall;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc        <= resetPc;
            reqActive <= 1'b0;
            bufValid  <= 1'b0;
        end else begin
            if (reqActive && instValid) begin
                reqActive <= 1'b0;
                pc        <= pc + 32'd4;
            end else if (!reqActive && !decodeStall) begin
                reqActive <= 1'b1;
            end

            if (reqActive && instValid) begin
                bufValid <= 1'b1;
            end else if (fetchValid) begin
                bufValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reqActive && instValid) begin
            fetchInst <= instRdata;
            fetchPc   <= pc;
        end
    end

endmodule

`default_nettype wire

// File: pipePkg.sv
`default_nettype none

package pipePkg;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluLui
    } aluOp_t;

    typedef enum logic [1:0] {
        memNone,
        memLoad,
        memStore
    } memOp_t;

    // Where the register write value comes from
    typedef enum logic [1:0] {
        wbNone,
        wbAlu,
        wbMem
    } wbSrc_t;

endpackage

`default_nettype wire

// File: isaPkg.sv
`default_nettype none

package isaPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;

    // Primary opcode field in bits 31:26
    typedef enum logic [5:0] {
        opSpecial = 6'h00,
        opAddiu   = 6'h09,
        opAndi    = 6'h0c,
        opOri     = 6'h0d,
        opLui     = 6'h0f,
        opLw      = 6'h23,
        opSw      = 6'h2b
    } opcode_t;

    // Function field of SPECIAL in bits 5:0
    typedef enum logic [5:0] {
        fnAddu = 6'h21,
        fnSubu = 6'h23,
        fnAnd  = 6'h24,
        fnOr   = 6'h25,
        fnXor  = 6'h26,
        fnSlt  = 6'h2a
    } funct_t;

endpackage

`default_nettype wire
